// ==== img_filter.f ====
+incdir+hdl
hdl/img_filter_pkg.sv
hdl/image_ram.sv
hdl/row_buffer.sv
hdl/window_fetch.sv
hdl/median_filter.sv
hdl/img_filter_top.sv
test/img_filter_assertions.sv
test/img_filter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f img_filter.f \
    --top-module img_filter_tb \
    -Mdir "$BUILD_DIR" -o img_filter_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/img_filter_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== test/img_filter_tb.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module img_filter_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `IMG_WIDTH;
    localparam int H = `IMG_HEIGHT;
    localparam int NPIX = W * H;
    localparam int NUM_TESTS = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (NPIX * 20 + 200);

    typedef enum int {PAT_ZERO, PAT_CONST, PAT_RAMP, PAT_DOT, PAT_RAND} pattern_t;

    typedef struct {
        string name;
        pattern_t kind;
        img_filter_pkg::pixel_t value;
        img_filter_pkg::pixel_t interior;
        int passes;
        bit stall;
    } test_entry_t;

    logic clk;
    logic rst;
    logic start;
    logic host_we;
    logic host_rd;
    img_filter_pkg::img_addr_t host_addr;
    img_filter_pkg::pixel_t host_wdata;
    logic busy;
    logic done;
    img_filter_pkg::pixel_t host_rdata;

    test_entry_t tests [NUM_TESTS];
    img_filter_pkg::pixel_t orig [NPIX];
    img_filter_pkg::pixel_t expect_img [NPIX];
    int pixel_errors = 0;
    int flag_errors = 0;
    int cycle_count = 0;

    img_filter_top u_img_filter_top (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .host_we    (host_we),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .busy       (busy),
        .done       (done),
        .host_rdata (host_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_pixel(input string name, input img_filter_pkg::pixel_t expected,
                               input img_filter_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            pixel_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            flag_errors++;
        end
    endtask

    // Inputs change 10 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic read_pixel(input int addr, output img_filter_pkg::pixel_t value);
        host_rd = 1'b1;
        host_addr = img_filter_pkg::img_addr_t'(addr);
        wait_cycle();
        host_rd = 1'b0;
        value = host_rdata;
    endtask

    task automatic load_image(input test_entry_t t);
        int r;
        int c;
        for (int i = 0; i < NPIX; i++) begin
            r = i / W;
            c = i % W;
            case (t.kind)
                PAT_ZERO: orig[i] = '0;
                PAT_CONST: orig[i] = t.value;
                PAT_RAMP: orig[i] = img_filter_pkg::pixel_t'(i * int'(t.value));
                PAT_DOT: orig[i] = (r == 2 && c == 3) ? t.value : '0;
                default: orig[i] = img_filter_pkg::pixel_t'($urandom);
            endcase
            host_we = 1'b1;
            host_addr = img_filter_pkg::img_addr_t'(i);
            host_wdata = orig[i];
            wait_cycle();
        end
        host_we = 1'b0;
    endtask

    // Median of the zero-padded 3x3 neighbourhood
    task automatic apply_model();
        img_filter_pkg::pixel_t nb [9];
        img_filter_pkg::pixel_t tmp;
        int n;
        int j;
        int rr;
        int cc;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                n = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = r + dr;
                        cc = c + dc;
                        nb[n] = (rr >= 0 && rr < H && cc >= 0 && cc < W) ? orig[rr * W + cc] : '0;
                        n++;
                    end
                end
                for (int i = 1; i < 9; i++) begin
                    tmp = nb[i];
                    j = i - 1;
                    while (j >= 0 && nb[j] > tmp) begin
                        nb[j + 1] = nb[j];
                        j--;
                    end
                    nb[j + 1] = tmp;
                end
                expect_img[r * W + c] = nb[4];
            end
        end
    endtask

    task automatic run_filter(input test_entry_t t);
        img_filter_pkg::pixel_t value;
        int addr;
        start = 1'b1;
        wait_cycle();
        start = 1'b0;
        check_flag({t.name, " busy after start"}, 1'b1, busy);
        while (done !== 1'b1) begin
            if (t.stall && ($urandom % 4) == 0) begin
                // Interior of a constant image stays constant through the pass
                addr = (1 + int'($urandom % (H - 2))) * W + 1 + int'($urandom % (W - 2));
                read_pixel(addr, value);
                check_pixel($sformatf("%s stall read %0d", t.name, addr), t.value, value);
            end else begin
                wait_cycle();
            end
        end
        check_flag({t.name, " busy at done"}, 1'b1, busy);
        wait_cycle();
        check_flag({t.name, " busy after done"}, 1'b0, busy);
        check_flag({t.name, " done pulse width"}, 1'b0, done);
    endtask

    task automatic check_image(input test_entry_t t, input int pass);
        img_filter_pkg::pixel_t value;
        string name;
        for (int i = 0; i < NPIX; i++) begin
            read_pixel(i, value);
            name = $sformatf("%s pass %0d pixel %0d", t.name, pass, i);
            check_pixel(name, expect_img[i], value);
            if ((t.kind == PAT_ZERO || t.kind == PAT_CONST) && i / W > 0 && i / W < H - 1 &&
                i % W > 0 && i % W < W - 1) begin
                check_pixel({name, " interior"}, t.interior, value);
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int assert_errors;
        void'($urandom(32'hda8f_458f));
        rst = 1'b1;
        start = 1'b0;
        host_we = 1'b0;
        host_rd = 1'b0;
        host_addr = '0;
        host_wdata = '0;

        tests[0] = '{"zero", PAT_ZERO, 8'h00, 8'h00, 1, 1'b0};
        tests[1] = '{"constant", PAT_CONST, 8'hc8, 8'hc8, 1, 1'b0};
        tests[2] = '{"ramp", PAT_RAMP, 8'h05, 8'h00, 1, 1'b0};
        tests[3] = '{"bright_pixel", PAT_DOT, 8'hff, 8'h00, 1, 1'b0};
        tests[4] = '{"random", PAT_RAND, 8'h00, 8'h00, 1, 1'b0};
        tests[5] = '{"host_stall", PAT_CONST, 8'h5a, 8'h5a, 1, 1'b1};
        tests[6] = '{"two_passes", PAT_RAND, 8'h00, 8'h00, 2, 1'b0};

        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);

        foreach (tests[t]) begin
            load_image(tests[t]);
            apply_model();
            for (int p = 0; p < tests[t].passes; p++) begin
                run_filter(tests[t]);
                check_image(tests[t], p);
                // Next pass filters the filtered image
                orig = expect_img;
                apply_model();
            end
        end

        assert_errors = int'(u_img_filter_top.u_window_fetch.u_fetch_assertions.failures);
        $display("Errors: pixel %0d, flag %0d, assertion %0d",
                 pixel_errors, flag_errors, assert_errors);
        if (pixel_errors + flag_errors + assert_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/img_filter_assertions.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module img_filter_assertions (
    input wire clk,
    input wire rst,
    input wire window_valid,
    input wire result_valid,
    input wire busy,
    input wire done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures
    int unsigned failures = 0;

    // Filter answers each window after a fixed latency
    result_latency: assert property (@(posedge clk) disable iff (rst)
        result_valid == $past(window_valid, `MED_LATENCY))
        else begin
            $error("result_valid did not follow window_valid after the filter latency");
            failures = failures + 1;
        end

    window_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        window_valid |=> !window_valid)
        else begin
            $error("window_valid held high for more than one cycle");
            failures = failures + 1;
        end

    done_inside_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else begin
            $error("done pulsed while busy was low");
            failures = failures + 1;
        end

endmodule

bind window_fetch img_filter_assertions u_fetch_assertions (
    .clk          (clk),
    .rst          (rst),
    .window_valid (window_valid),
    .result_valid (result_valid),
    .busy         (busy),
    .done         (done)
);

`default_nettype wire

// ==== hdl/img_filter_top.sv ====
`default_nettype none

module img_filter_top (
    input wire clk,
    input wire rst,
    input wire start,
    input wire host_we,
    input wire host_rd,
    input wire img_filter_pkg::img_addr_t host_addr,
    input wire img_filter_pkg::pixel_t host_wdata,
    output logic busy,
    output logic done,
    output img_filter_pkg::pixel_t host_rdata
);

    // Image RAM port of the controller
    logic avail;
    logic ram_ce;
    logic ram_we;
    img_filter_pkg::img_addr_t ram_addr;
    img_filter_pkg::pixel_t ram_wdata;

    // Row buffer
    logic rb_we;
    img_filter_pkg::col_t rb_waddr;
    logic rb_wrow;
    img_filter_pkg::pixel_t rb_wdata;
    img_filter_pkg::col_t rb_raddr;
    logic rb_rrow;
    img_filter_pkg::pixel_t rb_rdata;

    // Median filter
    logic window_valid;
    img_filter_pkg::window_t window;
    logic result_valid;
    img_filter_pkg::pixel_t result;

    image_ram u_image_ram (
        .clk        (clk),
        .host_we    (host_we),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .ram_ce     (ram_ce),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .rdata      (host_rdata),
        .avail      (avail)
    );

    row_buffer u_row_buffer (
        .clk   (clk),
        .we    (rb_we),
        .waddr (rb_waddr),
        .wrow  (rb_wrow),
        .wdata (rb_wdata),
        .raddr (rb_raddr),
        .rrow  (rb_rrow),
        .rdata (rb_rdata)
    );

    // The controller sees the same read data as the host
    window_fetch u_window_fetch (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .avail        (avail),
        .ram_rdata    (host_rdata),
        .rb_rdata     (rb_rdata),
        .result_valid (result_valid),
        .result       (result),
        .busy         (busy),
        .done         (done),
        .ram_ce       (ram_ce),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .rb_we        (rb_we),
        .rb_waddr     (rb_waddr),
        .rb_wrow      (rb_wrow),
        .rb_wdata     (rb_wdata),
        .rb_raddr     (rb_raddr),
        .rb_rrow      (rb_rrow),
        .window_valid (window_valid),
        .window       (window)
    );

    median_filter u_median_filter (
        .clk          (clk),
        .rst          (rst),
        .window_valid (window_valid),
        .window       (window),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// ==== hdl/median_filter.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module median_filter (
    input wire clk,
    input wire rst,
    input wire window_valid,
    input wire img_filter_pkg::window_t window,
    output logic result_valid,
    output img_filter_pkg::pixel_t result
);

    img_filter_pkg::window_t s1_d;
    img_filter_pkg::window_t s1_q;
    img_filter_pkg::window_t s2_d;
    img_filter_pkg::window_t s2_q;
    img_filter_pkg::window_t s3_d;
    logic [`MED_LATENCY-1:0] vld_q;

    // Compare-exchange, smaller value ends at index a
    function automatic img_filter_pkg::window_t cx(
        input img_filter_pkg::window_t p,
        input int unsigned a,
        input int unsigned b
    );
        img_filter_pkg::window_t q;
        q = p;
        if (p[a] > p[b]) begin
            q[a] = p[b];
            q[b] = p[a];
        end
        return q;
    endfunction

    ////////////////////////////////////////
    // Stage 1, sort the triples
    ////////////////////////////////////////

    always_comb begin
        s1_d = window;
        s1_d = cx(s1_d, 1, 2);
        s1_d = cx(s1_d, 4, 5);
        s1_d = cx(s1_d, 7, 8);
        s1_d = cx(s1_d, 0, 1);
        s1_d = cx(s1_d, 3, 4);
        s1_d = cx(s1_d, 6, 7);
        s1_d = cx(s1_d, 1, 2);
        s1_d = cx(s1_d, 4, 5);
        s1_d = cx(s1_d, 7, 8);
    end

    ////////////////////////////////////////
    // Stage 2, merge across triples
    ////////////////////////////////////////

    always_comb begin
        s2_d = s1_q;
        s2_d = cx(s2_d, 0, 3);
        s2_d = cx(s2_d, 5, 8);
        s2_d = cx(s2_d, 4, 7);
        s2_d = cx(s2_d, 3, 6);
        s2_d = cx(s2_d, 1, 4);
        s2_d = cx(s2_d, 2, 5);
    end

    ////////////////////////////////////////
    // Stage 3, narrow to the median
    ////////////////////////////////////////

    always_comb begin
        s3_d = s2_q;
        s3_d = cx(s3_d, 4, 7);
        s3_d = cx(s3_d, 4, 2);
        s3_d = cx(s3_d, 6, 4);
        s3_d = cx(s3_d, 4, 2);
    end

    always_ff @(posedge clk) begin
        s1_q <= s1_d;
        s2_q <= s2_d;
        result <= s3_d[4];
    end

    // Valid travels alongside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`MED_LATENCY-2:0], window_valid};
        end
    end

    assign result_valid = vld_q[`MED_LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/window_fetch.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module window_fetch (
    input wire clk,
    input wire rst,
    input wire start,
    input wire avail,
    input wire img_filter_pkg::pixel_t ram_rdata,
    input wire img_filter_pkg::pixel_t rb_rdata,
    input wire result_valid,
    input wire img_filter_pkg::pixel_t result,
    output logic busy,
    output logic done,
    output logic ram_ce,
    output logic ram_we,
    output img_filter_pkg::img_addr_t ram_addr,
    output img_filter_pkg::pixel_t ram_wdata,
    output logic rb_we,
    output img_filter_pkg::col_t rb_waddr,
    output logic rb_wrow,
    output img_filter_pkg::pixel_t rb_wdata,
    output img_filter_pkg::col_t rb_raddr,
    output logic rb_rrow,
    output logic window_valid,
    output img_filter_pkg::window_t window
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD,
        ISSUE,
        WAIT_RESULT,
        WRITE_BACK
    } state_t;

    state_t state;

    // Centre pixel position
    img_filter_pkg::row_t row_idx;
    img_filter_pkg::col_t col_idx;

    // Window slot being fetched
    logic [1:0] win_row;
    logic [1:0] win_col;

    img_filter_pkg::row_t fetch_row;
    img_filter_pkg::col_t fetch_col;
    img_filter_pkg::img_addr_t fetch_addr;
    img_filter_pkg::img_addr_t centre_addr;
    logic off_image;
    logic rd_req;
    logic last_pixel;
    logic [3:0] win_idx;
    img_filter_pkg::pixel_t load_pix;
    img_filter_pkg::window_t win_q;
    img_filter_pkg::pixel_t res_q;

    ////////////////////////////////////////
    // Fetch position
    ////////////////////////////////////////

    assign fetch_row = row_idx + {1'b0, win_row} - 3'd1;
    assign fetch_col = col_idx + {1'b0, win_col} - 3'd1;

    // Zero padding around the image
    assign off_image = (win_row == 2'd0 && row_idx == 3'd0) ||
                       (win_row == 2'd2 && row_idx == img_filter_pkg::row_t'(`IMG_HEIGHT - 1)) ||
                       (win_col == 2'd0 && col_idx == 3'd0) ||
                       (win_col == 2'd2 && col_idx == img_filter_pkg::col_t'(`IMG_WIDTH - 1));

    assign fetch_addr = img_filter_pkg::img_addr_t'(fetch_row)
                        * img_filter_pkg::img_addr_t'(`IMG_WIDTH)
                        + img_filter_pkg::img_addr_t'(fetch_col);
    assign centre_addr = img_filter_pkg::img_addr_t'(row_idx)
                         * img_filter_pkg::img_addr_t'(`IMG_WIDTH)
                         + img_filter_pkg::img_addr_t'(col_idx);

    assign last_pixel = (row_idx == img_filter_pkg::row_t'(`IMG_HEIGHT - 1)) &&
                        (col_idx == img_filter_pkg::col_t'(`IMG_WIDTH - 1));

    assign win_idx = {2'b00, win_row} * 4'd3 + {2'b00, win_col};

    // Upper row comes from the row buffer, the others from the RAM
    assign load_pix = off_image ? '0 : (win_row == 2'd0) ? rb_rdata : ram_rdata;

    ////////////////////////////////////////
    // Memory strobes
    ////////////////////////////////////////

    assign rd_req = (state == FETCH) && !off_image && (win_row != 2'd0) && avail;
    assign ram_we = (state == WRITE_BACK) && avail;
    assign ram_ce = rd_req | ram_we;
    assign ram_addr = (state == WRITE_BACK) ? centre_addr : fetch_addr;
    assign ram_wdata = res_q;

    // Middle row originals go to the row buffer
    assign rb_we = (state == LOAD) && !off_image && (win_row == 2'd1);
    assign rb_waddr = fetch_col;
    assign rb_wrow = row_idx[0];
    assign rb_wdata = ram_rdata;
    assign rb_raddr = fetch_col;
    assign rb_rrow = ~row_idx[0];

    assign window_valid = (state == ISSUE);
    assign window = win_q;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            row_idx <= '0;
            col_idx <= '0;
            win_row <= '0;
            win_col <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        busy <= 1'b1;
                        row_idx <= '0;
                        col_idx <= '0;
                        win_row <= '0;
                        win_col <= '0;
                        state <= FETCH;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                FETCH: begin
                    if (off_image || win_row == 2'd0 || avail) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (win_row == 2'd2) begin
                        win_row <= '0;
                        if (win_col == 2'd2) begin
                            state <= ISSUE;
                        end else begin
                            win_col <= win_col + 2'd1;
                            state <= FETCH;
                        end
                    end else begin
                        win_row <= win_row + 2'd1;
                        state <= FETCH;
                    end
                end
                ISSUE: begin
                    state <= WAIT_RESULT;
                end
                WAIT_RESULT: begin
                    if (result_valid) begin
                        state <= WRITE_BACK;
                    end
                end
                WRITE_BACK: begin
                    if (avail) begin
                        if (last_pixel) begin
                            done <= 1'b1;
                            state <= IDLE;
                        end else if (col_idx == img_filter_pkg::col_t'(`IMG_WIDTH - 1)) begin
                            // New row refetches all three columns
                            row_idx <= row_idx + 3'd1;
                            col_idx <= '0;
                            win_col <= 2'd0;
                            state <= FETCH;
                        end else begin
                            col_idx <= col_idx + 3'd1;
                            win_col <= 2'd2;
                            state <= FETCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Window contents and filter result
    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            win_q[win_idx] <= load_pix;
        end
        if (state == WAIT_RESULT && result_valid) begin
            res_q <= result;
        end
        if (state == WRITE_BACK && avail && !last_pixel &&
            col_idx != img_filter_pkg::col_t'(`IMG_WIDTH - 1)) begin
            for (int r = 0; r < 3; r++) begin
                win_q[r * 3] <= win_q[r * 3 + 1];
                win_q[r * 3 + 1] <= win_q[r * 3 + 2];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/row_buffer.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module row_buffer (
    input wire clk,
    input wire we,
    input wire img_filter_pkg::col_t waddr,
    input wire wrow,
    input wire img_filter_pkg::pixel_t wdata,
    input wire img_filter_pkg::col_t raddr,
    input wire rrow,
    output img_filter_pkg::pixel_t rdata
);

    // Two rows, selected by row parity
    localparam int DEPTH = 2 * `IMG_WIDTH;

    img_filter_pkg::pixel_t mem [DEPTH];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[{wrow, waddr}] <= wdata;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Reads the other parity, so never collides with the write
    always_ff @(posedge clk) begin
        rdata <= mem[{rrow, raddr}];
    end

endmodule

`default_nettype wire

// ==== hdl/image_ram.sv ====
`default_nettype none

`include "img_filter_consts.svh"

module image_ram (
    input wire clk,
    input wire host_we,
    input wire host_rd,
    input wire img_filter_pkg::img_addr_t host_addr,
    input wire img_filter_pkg::pixel_t host_wdata,
    input wire ram_ce,
    input wire ram_we,
    input wire img_filter_pkg::img_addr_t ram_addr,
    input wire img_filter_pkg::pixel_t ram_wdata,
    output img_filter_pkg::pixel_t rdata,
    output logic avail
);

    localparam int DEPTH = `IMG_WIDTH * `IMG_HEIGHT;

    img_filter_pkg::pixel_t mem [DEPTH];
    logic host_access;
    img_filter_pkg::img_addr_t rd_addr;

    // Host owns the port whenever it reads or writes
    assign host_access = host_we | host_rd;
    assign avail = ~host_access;
    assign rd_addr = host_access ? host_addr : ram_addr;

    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end else if (ram_ce && ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // Registered read, held when nobody accesses
    always_ff @(posedge clk) begin
        if (host_access || ram_ce) begin
            rdata <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/img_filter_pkg.sv ====
`default_nettype none

`include "img_filter_consts.svh"

package img_filter_pkg;

    // One greyscale pixel
    typedef logic [`PIX_BITS-1:0] pixel_t;

    // Linear image address
    typedef logic [`IMG_ADDR_BITS-1:0] img_addr_t;

    // Column and row indices
    typedef logic [2:0] col_t;
    typedef logic [2:0] row_t;

    // 3x3 window, row-major, index 4 is the centre
    typedef pixel_t [8:0] window_t;

endpackage

`default_nettype wire

// ==== hdl/img_filter_consts.svh ====
`ifndef IMG_FILTER_CONSTS_SVH
`define IMG_FILTER_CONSTS_SVH

// Image geometry
`define IMG_WIDTH 8
`define IMG_HEIGHT 6

// Pixel width in bits
`define PIX_BITS 8

// Linear address is row * IMG_WIDTH + column
`define IMG_ADDR_BITS 6

// Cycles from window_valid to result_valid
`define MED_LATENCY 3

`endif
